//--- build.f
source/uart_cmd_pkg.sv
source/cmd_sequencer.sv
source/uart_tx_frame.sv
source/uart_rx_frame.sv
source/uart_cmd_top.sv
test/uart_cmd_sva.sv
test/uart_cmd_tb.sv

//--- Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module uart_cmd_tb -f build.f
	./obj_dir/Vuart_cmd_tb > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "test failed"; exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG) || { echo "test did not complete"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

//--- test/uart_cmd_tb.sv
`timescale 1ns/10ps

module uart_cmd_tb;

  logic                       clk;
  logic                       rst_n;
  uart_cmd_pkg::cmd_word_u    cmd;
  logic                       cmd_vld;
  logic                       rx;
  logic                       cmd_rdy;
  logic                       tx;
  logic                       read_rdy;
  uart_cmd_pkg::read_result_t read_result;

  // remote register file and the host-side expectation of it
  logic [7:0] dev_mem [128];
  logic [7:0] exp_mem [128];

  uart_cmd_top u_uart_cmd_top (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd        (cmd),
    .cmd_vld    (cmd_vld),
    .rx         (rx),
    .cmd_rdy    (cmd_rdy),
    .tx         (tx),
    .read_rdy   (read_rdy),
    .read_result(read_result)
  );

  always #20 clk = ~clk;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  // advance n clocks and land 2 ns after the edge
  task automatic step(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  // longest command is an address frame, the reply window and a reply frame
  function automatic int cycle_limit();
    return (2 * uart_cmd_pkg::frame_bits + uart_cmd_pkg::reply_timeout_bits + 8) *
           uart_cmd_pkg::bit_cycles;
  endfunction

  task automatic recv_frame(output logic [7:0] data);
    int waited;
    waited = 0;
    while (tx !== 1'b0) begin
      step(1);
      waited++;
      if (waited > cycle_limit()) begin
        fail_run("no start bit seen on tx");
      end
    end
    step(uart_cmd_pkg::bit_cycles / 2);
    check("tx start bit", 32'(tx), 32'h0);
    for (int i = 0; i < 8; i++) begin
      step(uart_cmd_pkg::bit_cycles);
      data[i] = tx;
    end
    step(uart_cmd_pkg::bit_cycles);
    check("tx parity bit", 32'(tx), 32'(~^data));
    step(uart_cmd_pkg::bit_cycles);
    check("tx stop bit", 32'(tx), 32'h1);
  endtask

  task automatic send_frame(input logic [7:0] data, input logic bad_parity);
    logic [9:0] bits;
    bits = {(~^data) ^ bad_parity, data, 1'b0};
    for (int i = 0; i < 10; i++) begin
      rx = bits[i];
      step(uart_cmd_pkg::bit_cycles);
    end
    // stop bit and then the idle level
    rx = 1'b1;
  endtask

  task automatic poke_while_busy();
    int waited;
    waited = 0;
    while (cmd_rdy !== 1'b1) begin
      cmd_vld = ($urandom_range(3) == 0);
      cmd     = 16'($urandom);
      step(1);
      waited++;
      if (waited > cycle_limit()) begin
        fail_run("cmd_rdy stayed low, command never completed");
      end
    end
    cmd_vld = 1'b0;
  endtask

  // kind 0 good reply, 1 bad parity, 2 silent
  task automatic device_side(input logic rw, input logic [6:0] addr, input logic [7:0] data,
                             input int kind);
    logic [7:0]                 first;
    logic [7:0]                 second;
    uart_cmd_pkg::read_result_t exp_res;
    int                         waited;
    int                         gap;
    waited = 0;
    recv_frame(first);
    check("tx address byte", 32'(first), 32'({rw, addr}));
    if (!first[7]) begin
      recv_frame(second);
      check("tx data byte", 32'(second), 32'(data));
      dev_mem[first[6:0]] = second;
      while (cmd_rdy !== 1'b1) begin
        check("read_rdy", 32'(read_rdy), 32'h0);
        step(1);
        waited++;
        if (waited > cycle_limit()) begin
          fail_run("write never completed");
        end
      end
      check("read_rdy", 32'(read_rdy), 32'h0);
    end else begin
      gap = uart_cmd_pkg::bit_cycles * int'($urandom_range(5, 1));
      step(uart_cmd_pkg::bit_cycles / 2 + gap);
      if (kind == 2) begin
        exp_res = {1'b1, 1'b0, 8'h00};
      end else begin
        send_frame(dev_mem[first[6:0]], kind == 1);
        exp_res = {1'b0, kind == 1, exp_mem[addr]};
      end
      while (read_rdy !== 1'b1) begin
        step(1);
        waited++;
        if (waited > cycle_limit()) begin
          fail_run("read_rdy never pulsed for a read");
        end
      end
      check("read_result", 32'(read_result), 32'(exp_res));
      check("cmd_rdy", 32'(cmd_rdy), 32'h1);
      step(1);
      check("read_rdy", 32'(read_rdy), 32'h0);
    end
  endtask

  task automatic run_cmd(input logic rw, input logic [6:0] addr, input logic [7:0] data,
                         input int kind);
    int waited;
    waited = 0;
    while (cmd_rdy !== 1'b1) begin
      step(1);
      waited++;
      if (waited > cycle_limit()) begin
        fail_run("cmd_rdy low before a new command");
      end
    end
    cmd     = {rw, addr, data};
    cmd_vld = 1'b1;
    step(1);
    check("cmd_rdy", 32'(cmd_rdy), 32'h0);
    fork
      poke_while_busy();
      device_side(rw, addr, data, kind);
    join
    if (!rw) begin
      exp_mem[addr] = data;
    end
  endtask

  initial begin
    void'($urandom(32'h1951_709f));
    clk     = 1'b0;
    rst_n   = 1'b0;
    cmd     = '0;
    cmd_vld = 1'b0;
    rx      = 1'b1;
    for (int i = 0; i < 128; i++) begin
      dev_mem[i] = 8'h00;
      exp_mem[i] = 8'h00;
    end
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;
    step(1);
    check("cmd_rdy", 32'(cmd_rdy), 32'h1);
    check("tx", 32'(tx), 32'h1);
    check("read_rdy", 32'(read_rdy), 32'h0);
    // directed write and then each reply kind on the same address
    run_cmd(1'b0, 7'h15, 8'ha5, 0);
    run_cmd(1'b1, 7'h15, 8'h00, 0);
    run_cmd(1'b1, 7'h15, 8'h00, 1);
    run_cmd(1'b1, 7'h15, 8'h00, 2);
    for (int n = 0; n < 200; n++) begin
      run_cmd(1'($urandom_range(1)), 7'($urandom), 8'($urandom), int'($urandom_range(2)));
    end
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

//--- test/uart_cmd_sva.sv
`timescale 1ns/10ps

module uart_cmd_sva (
  input logic clk,
  input logic rst_n,
  input logic cmd_vld,
  input logic cmd_rdy,
  input logic tx,
  input logic tx_busy,
  input logic read_rdy
);

  // line rests high between frames
  a_tx_idle: assert property (@(posedge clk) disable iff (!rst_n) !tx_busy |-> tx)
    else $error("tx low while no frame is in progress");

  a_read_pulse: assert property (@(posedge clk) disable iff (!rst_n) read_rdy |=> !read_rdy)
    else $error("read_rdy held longer than one cycle");

  a_accept: assert property (@(posedge clk) disable iff (!rst_n)
                             cmd_vld && cmd_rdy |=> !cmd_rdy)
    else $error("cmd_rdy still high after an accepted command");

  a_read_done: assert property (@(posedge clk) disable iff (!rst_n) read_rdy |-> cmd_rdy)
    else $error("read_rdy high while cmd_rdy is low");

endmodule

bind uart_cmd_top uart_cmd_sva u_uart_cmd_sva (
  .clk     (clk),
  .rst_n   (rst_n),
  .cmd_vld (cmd_vld),
  .cmd_rdy (cmd_rdy),
  .tx      (tx),
  .tx_busy (tx_busy),
  .read_rdy(read_rdy)
);

//--- source/uart_cmd_top.sv
`timescale 1ns/10ps

module uart_cmd_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  uart_cmd_pkg::cmd_word_u    cmd,
  input  logic                       cmd_vld,
  input  logic                       rx,
  output logic                       cmd_rdy,
  output logic                       tx,
  output logic                       read_rdy,
  output uart_cmd_pkg::read_result_t read_result
);

  logic                       tx_start;
  logic [7:0]                 tx_byte;
  logic                       tx_busy;
  logic                       rx_arm;
  logic                       rx_done;
  uart_cmd_pkg::read_result_t rx_result;

  cmd_sequencer u_cmd_sequencer (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd        (cmd),
    .cmd_vld    (cmd_vld),
    .tx_busy    (tx_busy),
    .rx_done    (rx_done),
    .rx_result  (rx_result),
    .cmd_rdy    (cmd_rdy),
    .tx_start   (tx_start),
    .tx_byte    (tx_byte),
    .rx_arm     (rx_arm),
    .read_rdy   (read_rdy),
    .read_result(read_result)
  );

  uart_tx_frame u_uart_tx_frame (
    .clk     (clk),
    .rst_n   (rst_n),
    .tx_start(tx_start),
    .tx_byte (tx_byte),
    .tx      (tx),
    .tx_busy (tx_busy)
  );

  uart_rx_frame u_uart_rx_frame (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx       (rx),
    .rx_arm   (rx_arm),
    .rx_done  (rx_done),
    .rx_result(rx_result)
  );

endmodule

//--- source/uart_rx_frame.sv
`timescale 1ns/10ps

module uart_rx_frame (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       rx,
  input  logic                       rx_arm,
  output logic                       rx_done,
  output uart_cmd_pkg::read_result_t rx_result
);

  typedef enum logic [1:0] {
    rx_idle,
    rx_wait,
    rx_start,
    rx_bits
  } rx_state_t;

  rx_state_t state;
  logic      rx_s1;
  logic      rx_s2;
  logic      rx_s3;
  logic [$clog2(uart_cmd_pkg::bit_cycles)-1:0] baud_cnt;
  logic [3:0] bit_cnt;
  logic [$clog2(uart_cmd_pkg::timeout_cycles + uart_cmd_pkg::bit_cycles)-1:0] tout_cnt;
  logic [8:0] sh;
  logic       fall;
  logic       half_tick;
  logic       bit_tick;
  logic       stop_tick;
  logic       tout_hit;

  assign fall      = rx_s3 && !rx_s2;
  assign half_tick = state == rx_start &&
                     baud_cnt == $bits(baud_cnt)'(uart_cmd_pkg::bit_cycles / 2 - 1);
  assign bit_tick  = state == rx_bits &&
                     baud_cnt == $bits(baud_cnt)'(uart_cmd_pkg::bit_cycles - 1);
  // eight data bits and parity come before the stop bit
  assign stop_tick = bit_tick && bit_cnt == 4'd9;
  assign tout_hit  = state == rx_wait && !fall &&
                     tout_cnt >= $bits(tout_cnt)'(uart_cmd_pkg::timeout_cycles - 1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= rx_idle;
      rx_s1    <= 1'b1;
      rx_s2    <= 1'b1;
      rx_s3    <= 1'b1;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      tout_cnt <= '0;
      rx_done  <= 1'b0;
    end else begin
      rx_s1   <= rx;
      rx_s2   <= rx_s1;
      rx_s3   <= rx_s2;
      rx_done <= 1'b0;
      case (state)
        rx_idle: begin
          if (rx_arm) begin
            tout_cnt <= '0;
            state    <= rx_wait;
          end
        end
        rx_wait: begin
          tout_cnt <= tout_cnt + 1'b1;
          if (fall) begin
            baud_cnt <= '0;
            state    <= rx_start;
          end else if (tout_hit) begin
            rx_done <= 1'b1;
            state   <= rx_idle;
          end
        end
        rx_start: begin
          // timeout keeps running through a false start
          tout_cnt <= tout_cnt + 1'b1;
          baud_cnt <= baud_cnt + 1'b1;
          if (half_tick) begin
            baud_cnt <= '0;
            bit_cnt  <= '0;
            state    <= rx_s2 ? rx_wait : rx_bits;
          end
        end
        default: begin
          if (bit_tick) begin
            baud_cnt <= '0;
            bit_cnt  <= bit_cnt + 1'b1;
            if (stop_tick) begin
              rx_done <= 1'b1;
              state   <= rx_idle;
            end
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (bit_tick && !stop_tick) begin
      sh <= {rx_s2, sh[8:1]};
    end
    if (stop_tick) begin
      rx_result.timeout   <= 1'b0;
      // odd parity over data plus parity bit, and stop must be high
      rx_result.frame_err <= !(^sh) || !rx_s2;
      rx_result.data      <= sh[7:0];
    end else if (tout_hit) begin
      rx_result.timeout   <= 1'b1;
      rx_result.frame_err <= 1'b0;
      rx_result.data      <= 8'h00;
    end
  end

endmodule

//--- source/uart_tx_frame.sv
`timescale 1ns/10ps

module uart_tx_frame (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tx_start,
  input  logic [7:0] tx_byte,
  output logic       tx,
  output logic       tx_busy
);

  logic [$clog2(uart_cmd_pkg::bit_cycles)-1:0] baud_cnt;
  logic [$clog2(uart_cmd_pkg::frame_bits)-1:0] bit_cnt;
  logic [uart_cmd_pkg::frame_bits-1:0]         shreg;
  logic                                        baud_end;
  logic                                        last_bit;

  assign baud_end = baud_cnt == $bits(baud_cnt)'(uart_cmd_pkg::bit_cycles - 1);
  assign last_bit = bit_cnt == $bits(bit_cnt)'(uart_cmd_pkg::frame_bits - 1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // all ones keeps the line idle high
      shreg    <= '1;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      tx_busy  <= 1'b0;
    end else if (!tx_busy) begin
      if (tx_start) begin
        // stop, odd parity, data, start
        shreg    <= {1'b1, ~^tx_byte, tx_byte, 1'b0};
        baud_cnt <= '0;
        bit_cnt  <= '0;
        tx_busy  <= 1'b1;
      end
    end else if (baud_end) begin
      baud_cnt <= '0;
      shreg    <= {1'b1, shreg[uart_cmd_pkg::frame_bits-1:1]};
      if (last_bit) begin
        tx_busy <= 1'b0;
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end else begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

  // lsb of the shift register drives the line
  assign tx = shreg[0];

endmodule

//--- source/cmd_sequencer.sv
`timescale 1ns/10ps

module cmd_sequencer (
  input  logic                       clk,
  input  logic                       rst_n,
  input  uart_cmd_pkg::cmd_word_u    cmd,
  input  logic                       cmd_vld,
  input  logic                       tx_busy,
  input  logic                       rx_done,
  input  uart_cmd_pkg::read_result_t rx_result,
  output logic                       cmd_rdy,
  output logic                       tx_start,
  output logic [7:0]                 tx_byte,
  output logic                       rx_arm,
  output logic                       read_rdy,
  output uart_cmd_pkg::read_result_t read_result
);

  typedef enum logic [2:0] {
    st_idle,
    st_send_addr,
    st_send_data,
    st_wait_reply,
    st_done
  } seq_state_t;

  seq_state_t              state;
  uart_cmd_pkg::cmd_word_u cmd_q;
  logic                    accept;
  logic                    frame_done;

  assign accept = cmd_vld && cmd_rdy;

  // tx_busy is still low in the cycle that carries tx_start
  assign frame_done = !tx_start && !tx_busy;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= st_idle;
      cmd_rdy  <= 1'b1;
      tx_start <= 1'b0;
      rx_arm   <= 1'b0;
      read_rdy <= 1'b0;
    end else begin
      tx_start <= 1'b0;
      rx_arm   <= 1'b0;
      read_rdy <= 1'b0;
      case (state)
        st_idle: begin
          if (accept) begin
            cmd_rdy  <= 1'b0;
            tx_start <= 1'b1;
            state    <= st_send_addr;
          end
        end
        st_send_addr: begin
          if (frame_done) begin
            if (cmd_q.rd.rw) begin
              rx_arm <= 1'b1;
              state  <= st_wait_reply;
            end else begin
              tx_start <= 1'b1;
              state    <= st_send_data;
            end
          end
        end
        st_send_data: begin
          if (frame_done) begin
            state <= st_done;
          end
        end
        st_wait_reply: begin
          if (rx_done) begin
            state <= st_done;
          end
        end
        default: begin
          // read_rdy and cmd_rdy rise together
          cmd_rdy  <= 1'b1;
          read_rdy <= cmd_q.rd.rw;
          state    <= st_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q   <= cmd;
      tx_byte <= {cmd.rd.rw, cmd.rd.addr};
    end else if (state == st_send_addr && frame_done && !cmd_q.wr.rw) begin
      tx_byte <= cmd_q.wr.data;
    end
    if (state == st_wait_reply && rx_done) begin
      read_result <= rx_result;
    end
  end

endmodule

//--- source/uart_cmd_pkg.sv
package uart_cmd_pkg;

  // serial timing in clock cycles and bit periods
  localparam int bit_cycles         = 16;
  localparam int frame_bits         = 11;
  localparam int reply_timeout_bits = 40;

  // reply window expressed in clock cycles
  localparam int timeout_cycles = reply_timeout_bits * bit_cycles;

  // write command with rw low
  typedef struct packed {
    logic       rw;
    logic [6:0] addr;
    logic [7:0] data;
  } cmd_wr_t;

  // read command with rw high and the low byte unused
  typedef struct packed {
    logic       rw;
    logic [6:0] addr;
    logic [7:0] pad;
  } cmd_rd_t;

  // upper byte goes out first in both views
  typedef union packed {
    cmd_wr_t wr;
    cmd_rd_t rd;
  } cmd_word_u;

  // reply status and byte returned to the host
  typedef struct packed {
    logic       timeout;
    logic       frame_err;
    logic [7:0] data;
  } read_result_t;

endpackage
